// File: hw/pulse_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pulse timing package
// command modes, field widths and run lengths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package pulse_pkg;

  // command modes, one per generator
  typedef enum logic [1:0] {
    one_shot = 2'd0,
    periodic = 2'd1,
    pwm      = 2'd2
  } pulse_mode_t;

  // length field in clock cycles
  typedef logic [7:0] pulse_len_t;

  // pulse count in periodic mode, high time in pwm mode
  typedef logic [7:0] pulse_wid_t;

  // cycle counter, one bit wider than the length so L+1 fits
  typedef logic [8:0] pulse_cyc_t;

  // periods run by one pwm command
  localparam int unsigned PWM_PERIODS = 4;

endpackage

`default_nettype wire

// File: hw/link_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// command link package
// queue depth and credit types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package link_pkg;

  // queue slots, also the credit count after reset
  localparam int unsigned FIFO_DEPTH = 4;

  typedef logic [2:0] credit_t;    // holds 0 .. FIFO_DEPTH
  typedef logic [1:0] fifo_ptr_t;  // wraps at FIFO_DEPTH

endpackage

`default_nettype wire

// File: hw/cmd_issuer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// command issuer
// stages host config, turns fire edges into
// commands and sends them against credits
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module cmd_issuer import pulse_pkg::*, link_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        cfg_load,
  input  pulse_mode_t cfg_mode,
  input  pulse_len_t  cfg_length,
  input  pulse_wid_t  cfg_width,
  input  logic        fire,
  input  logic        credit_ret,
  output logic        ready,
  output logic        cmd_push,
  output pulse_mode_t cmd_mode,
  output pulse_len_t  cmd_length,
  output pulse_wid_t  cmd_width
);

  pulse_mode_t stg_mode;
  pulse_len_t  stg_length;
  pulse_wid_t  stg_width;
  logic        fire_q;
  logic        pending;
  credit_t     credits;
  logic        issue;

  assign ready    = (credits != '0) && !pending;
  assign issue    = fire && !fire_q && ready;  // rising edge, dropped when not ready
  assign cmd_push = pending && (credits != '0);

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      stg_mode   <= one_shot;
      stg_length <= '0;
      stg_width  <= '0;
    end
    else if (cfg_load)
    begin
      stg_mode   <= cfg_mode;
      stg_length <= cfg_length;
      stg_width  <= cfg_width;
    end
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      fire_q  <= 1'b0;
      pending <= 1'b0;
    end
    else
    begin
      fire_q <= fire;
      if (issue)
        pending <= 1'b1;
      else if (cmd_push)
        pending <= 1'b0;
    end
  end

  // outgoing command, held until pushed
  always_ff @(posedge clk)
  begin
    if (issue)
    begin
      cmd_mode   <= stg_mode;
      cmd_length <= stg_length;
      cmd_width  <= stg_width;
    end
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      credits <= credit_t'(FIFO_DEPTH);
    else
    begin
      case ({cmd_push, credit_ret})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;  // both or neither
      endcase
    end
  end

  // returns from the queue can never outrun the pushes
  a_credit_max: assert property (@(posedge clk) disable iff (rst)
    credits <= credit_t'(FIFO_DEPTH));

endmodule

`default_nettype wire

// File: hw/cmd_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// command queue
// circular buffer, one credit back per take
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module cmd_fifo import pulse_pkg::*, link_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        cmd_push,
  input  pulse_mode_t cmd_mode,
  input  pulse_len_t  cmd_length,
  input  pulse_wid_t  cmd_width,
  input  logic        q_take,
  output logic        q_avail,
  output pulse_mode_t q_mode,
  output pulse_len_t  q_length,
  output pulse_wid_t  q_width,
  output logic        credit_ret
);

  pulse_mode_t mem_mode   [FIFO_DEPTH];
  pulse_len_t  mem_length [FIFO_DEPTH];
  pulse_wid_t  mem_width  [FIFO_DEPTH];
  fifo_ptr_t   wr_ptr;
  fifo_ptr_t   rd_ptr;
  credit_t     count;

  assign q_avail  = (count != '0);
  assign q_mode   = mem_mode[rd_ptr];  // head entry
  assign q_length = mem_length[rd_ptr];
  assign q_width  = mem_width[rd_ptr];

  always_ff @(posedge clk)
  begin
    if (cmd_push)
    begin
      mem_mode[wr_ptr]   <= cmd_mode;
      mem_length[wr_ptr] <= cmd_length;
      mem_width[wr_ptr]  <= cmd_width;
    end
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      credit_ret <= 1'b0;
    end
    else
    begin
      credit_ret <= q_take;  // one credit per removed entry
      if (cmd_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (q_take)
        rd_ptr <= rd_ptr + 1'b1;
      case ({cmd_push, q_take})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // the issuer's credit count keeps pushes off a full queue
  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    cmd_push |-> (count != credit_t'(FIFO_DEPTH)));

  a_no_underflow: assert property (@(posedge clk) disable iff (rst)
    q_take |-> (count != '0));

endmodule

`default_nettype wire

// File: hw/pulse_engine.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pulse engine
// takes one command at a time and drives
// a one-shot, periodic or pwm waveform
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module pulse_engine import pulse_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        q_avail,
  input  pulse_mode_t q_mode,
  input  pulse_len_t  q_length,
  input  pulse_wid_t  q_width,
  output logic        q_take,
  output logic        pulse_out,
  output logic        busy,
  output logic        done
);

  typedef enum logic [2:0] {
    idle,
    load,
    one_shot_run,
    periodic_run,
    pwm_run,
    finish
  } state_t;

  state_t     state;
  pulse_len_t cmd_length;
  pulse_wid_t cmd_width;
  pulse_cyc_t cyc_cnt;
  pulse_wid_t pulse_cnt;  // pulses in periodic, periods in pwm
  pulse_cyc_t len_ext;
  logic       period_end;
  logic       width_hit;
  logic       last_pulse;
  logic       last_period;

  assign len_ext = pulse_cyc_t'(cmd_length);

  // periodic spacing is one cycle longer than the pwm period
  assign period_end  = (state == periodic_run) ? (cyc_cnt == len_ext + 1'b1)
                                               : (cyc_cnt == len_ext);
  assign width_hit   = cyc_cnt < pulse_cyc_t'(cmd_width);
  assign last_pulse  = (pulse_cnt == cmd_width - 1'b1);
  assign last_period = (pulse_cnt == pulse_wid_t'(PWM_PERIODS - 1));

  assign q_take = (state == load);
  assign busy   = state inside {one_shot_run, periodic_run, pwm_run, finish};
  assign done   = (state == finish);

  always_comb
  begin
    case (state)
      one_shot_run: pulse_out = 1'b1;
      periodic_run: pulse_out = (cyc_cnt == '0);
      pwm_run:      pulse_out = width_hit;
      default:      pulse_out = 1'b0;  // load, idle and finish stay low
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (q_take)
    begin
      cmd_length <= q_length;
      cmd_width  <= q_width;
    end
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state     <= idle;
      cyc_cnt   <= '0;
      pulse_cnt <= '0;
    end
    else
    begin
      case (state)
        idle:
        begin
          if (q_avail)
            state <= load;
        end
        load:
        begin
          cyc_cnt   <= '0;
          pulse_cnt <= '0;
          case (q_mode)
            one_shot: state <= one_shot_run;
            periodic: state <= (q_width == '0) ? finish : periodic_run;
            pwm:      state <= pwm_run;
            default:  state <= finish;
          endcase
        end
        one_shot_run:
        begin
          cyc_cnt <= cyc_cnt + 1'b1;
          if (period_end)
            state <= finish;
        end
        periodic_run:
        begin
          if ((cyc_cnt == '0) && last_pulse)
            state <= finish;  // stop right after the last pulse
          else if (period_end)
          begin
            cyc_cnt   <= '0;
            pulse_cnt <= pulse_cnt + 1'b1;
          end
          else
            cyc_cnt <= cyc_cnt + 1'b1;
        end
        pwm_run:
        begin
          if (period_end)
          begin
            cyc_cnt   <= '0;
            pulse_cnt <= pulse_cnt + 1'b1;
            if (last_period)
              state <= finish;
          end
          else
            cyc_cnt <= cyc_cnt + 1'b1;
        end
        default:
          state <= idle;  // finish always goes back through idle
      endcase
    end
  end

  // q_avail was seen in idle and must still hold when the head is taken
  a_take_avail: assert property (@(posedge clk) disable iff (rst)
    q_take |-> q_avail);

  a_out_in_busy: assert property (@(posedge clk) disable iff (rst)
    !busy |-> !pulse_out);

endmodule

`default_nettype wire

// File: hw/pulse_unit_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pulse unit top
// issuer, command queue and pulse engine
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module pulse_unit_top import pulse_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        cfg_load,
  input  pulse_mode_t cfg_mode,
  input  pulse_len_t  cfg_length,
  input  pulse_wid_t  cfg_width,
  input  logic        fire,
  output logic        ready,
  output logic        pulse_out,
  output logic        busy,
  output logic        done
);

  logic        cmd_push;
  pulse_mode_t cmd_mode;
  pulse_len_t  cmd_length;
  pulse_wid_t  cmd_width;
  logic        credit_ret;
  logic        q_avail;
  logic        q_take;
  pulse_mode_t q_mode;
  pulse_len_t  q_length;
  pulse_wid_t  q_width;

  cmd_issuer u_issuer (
    .clk        (clk),
    .rst        (rst),
    .cfg_load   (cfg_load),
    .cfg_mode   (cfg_mode),
    .cfg_length (cfg_length),
    .cfg_width  (cfg_width),
    .fire       (fire),
    .credit_ret (credit_ret),
    .ready      (ready),
    .cmd_push   (cmd_push),
    .cmd_mode   (cmd_mode),
    .cmd_length (cmd_length),
    .cmd_width  (cmd_width)
  );

  cmd_fifo u_fifo (
    .clk        (clk),
    .rst        (rst),
    .cmd_push   (cmd_push),
    .cmd_mode   (cmd_mode),
    .cmd_length (cmd_length),
    .cmd_width  (cmd_width),
    .q_take     (q_take),
    .q_avail    (q_avail),
    .q_mode     (q_mode),
    .q_length   (q_length),
    .q_width    (q_width),
    .credit_ret (credit_ret)
  );

  pulse_engine u_engine (
    .clk       (clk),
    .rst       (rst),
    .q_avail   (q_avail),
    .q_mode    (q_mode),
    .q_length  (q_length),
    .q_width   (q_width),
    .q_take    (q_take),
    .pulse_out (pulse_out),
    .busy      (busy),
    .done      (done)
  );

endmodule

`default_nettype wire

// File: bench/tb_pulse_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pulse unit testbench
// random commands against a queue model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module tb_pulse_unit import pulse_pkg::*, link_pkg::*; ();

  localparam int N_CMDS      = 18;
  localparam int CYCLE_LIMIT = 16 + N_CMDS * 84 + 200;  // worst command near 80 cycles

  logic        clk = 1'b0;
  logic        rst = 1'b1;
  logic        cfg_load = 1'b0;
  pulse_mode_t cfg_mode = one_shot;
  pulse_len_t  cfg_length = '0;
  pulse_wid_t  cfg_width = '0;
  logic        fire = 1'b0;
  logic        ready;
  logic        pulse_out;
  logic        busy;
  logic        done;
  int          seed = 37627;
  int          value_errs = 0;
  int          other_errs = 0;
  int          cycles = 0;
  logic [17:0] model_mem [64];  // accepted commands as {mode, length, width}
  logic [17:0] stg = {one_shot, 16'd0};
  logic        fire_prev = 1'b0;
  int          wr_n = 0;
  int          rd_n = 0;
  int          ofs = 0;  // cycles into the current busy interval
  int          dropped = 0;

  function automatic logic expected_level(logic [17:0] c, int t);
    int l = int'(c[15:8]);
    int w = int'(c[7:0]);
    case (c[17:16])
      one_shot: expected_level = t <= l;
      periodic: expected_level = (t % (l + 2) == 0) && (t / (l + 2) < w);
      default:  expected_level = (t < int'(PWM_PERIODS) * (l + 1)) && (t % (l + 1) < w);
    endcase
  endfunction

  function automatic int busy_cycles(logic [17:0] c);
    int l = int'(c[15:8]);
    int w = int'(c[7:0]);
    case (c[17:16])
      one_shot: busy_cycles = l + 2;  // done cycle after the high stretch
      periodic: busy_cycles = (w == 0) ? 1 : (w - 1) * (l + 2) + 2;
      default:  busy_cycles = int'(PWM_PERIODS) * (l + 1) + 1;
    endcase
  endfunction

  task automatic value_err(string name, int exp_v, int got_v);
    value_errs++;
    $display("ERR %0t %s expected %0d got %0d", $time, name, exp_v, got_v);
  endtask

  task automatic other_err(string msg);
    other_errs++;
    $display("%s", msg);
  endtask

  wire exp_out  = busy && expected_level(model_mem[rd_n[5:0]], ofs);
  wire exp_done = busy && (ofs == busy_cycles(model_mem[rd_n[5:0]]) - 1);

  always #10 clk = ~clk;

  pulse_unit_top UUT (.*);

  // fire edge rule, busy interval tracking and the cycle limit
  always @(posedge clk)
  begin
    if (!rst)
    begin
      if (fire && !fire_prev && ready)
      begin
        model_mem[wr_n[5:0]] <= stg;
        wr_n <= wr_n + 1;
      end
      else if (fire && !fire_prev)
        dropped <= dropped + 1;
      if (cfg_load)
        stg <= {cfg_mode, cfg_length, cfg_width};
      fire_prev <= fire;
      ofs <= busy ? ofs + 1 : 0;
      if (done)
        rd_n <= rd_n + 1;  // head retires on its done cycle
    end
    cycles <= cycles + 1;
    if (cycles == CYCLE_LIMIT)
    begin
      $display("timeout after %0d cycles, the DUT never went idle", CYCLE_LIMIT);
      $display("TESTS FAILED");
      $finish;
    end
  end

  a_level: assert property (@(posedge clk) disable iff (rst) pulse_out == exp_out)
    else value_err("pulse_out", $sampled(exp_out), $sampled(pulse_out));
  a_done: assert property (@(posedge clk) disable iff (rst) done == exp_done)
    else value_err("done", $sampled(exp_done), $sampled(done));
  a_gap: assert property (@(posedge clk) disable iff (rst) done |=> !busy)
    else other_err("busy stayed high after done, no idle gap");
  a_no_extra: assert property (@(posedge clk) disable iff (rst)
    $rose(busy) |-> wr_n != rd_n)
    else other_err("busy interval started without an accepted command");
  a_full: assert property (@(posedge clk) disable iff (rst)
    (wr_n - rd_n >= int'(FIFO_DEPTH) + 1) |-> !ready)
    else value_err("ready", 0, $sampled(ready));
  // nothing outstanding, so every credit is back home
  a_idle_ready: assert property (@(posedge clk) disable iff (rst)
    (wr_n == rd_n) |-> ready)
    else value_err("ready", 1, $sampled(ready));

  task automatic issue_cmd(pulse_mode_t m, int l, int w);
    @(posedge clk);
    cfg_load   <= 1'b1;
    cfg_mode   <= m;
    cfg_length <= pulse_len_t'(l);
    cfg_width  <= pulse_wid_t'(w);
    fire       <= 1'b0;
    @(posedge clk);
    cfg_load <= 1'b0;
    fire     <= 1'b1;
  endtask

  // issue one command and wait until every accepted one has finished
  task automatic run_cmd(pulse_mode_t m, int l, int w);
    issue_cmd(m, l, w);
    @(posedge clk);
    fire <= 1'b0;
    repeat (2) @(posedge clk);
    while (busy || rd_n != wr_n)
      @(posedge clk);
  endtask

  initial
  begin
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    repeat (4) @(posedge clk);  // nothing may start before the first fire
    run_cmd(one_shot, 3, 0);
    run_cmd(one_shot, 0, 7);
    run_cmd(periodic, 2, 3);
    run_cmd(periodic, 5, 0);
    run_cmd(pwm, 3, 2);
    run_cmd(pwm, 2, 5);  // high time longer than the period
    issue_cmd(pwm, 7, 3);  // long head so the burst backs up
    for (int i = 0; i < N_CMDS - 8; i++)
      issue_cmd(pulse_mode_t'(2'({$random(seed)} % 3)),
                {$random(seed)} % 8, {$random(seed)} % 10);
    run_cmd(periodic, 1, 2);
    a_dropped: assert (dropped > 0)
      else other_err("no fire was dropped, the queue never filled");
    $display("errors: %0d value, %0d other", value_errs, other_errs);
    if (value_errs + other_errs == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
hw/pulse_pkg.sv
hw/link_pkg.sv
hw/cmd_issuer.sv
hw/cmd_fifo.sv
hw/pulse_engine.sv
hw/pulse_unit_top.sv
bench/tb_pulse_unit.sv

// File: Makefile
# Verilator build and run of the pulse unit testbench

VERILATOR ?= verilator
TOP       ?= tb_pulse_unit
FLIST     ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FLIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
